// ==== rv_pkg.sv ====
package rv_pkg;

	typedef enum logic [3:0] {
		OPC_LUI    = 4'd0,
		OPC_AUIPC  = 4'd1,
		OPC_JAL    = 4'd2,
		OPC_JALR   = 4'd3,
		OPC_BRANCH = 4'd4,
		OPC_STORE  = 4'd5,
		OPC_OP_IMM = 4'd6,
		OPC_OP     = 4'd7,
		OPC_SYSTEM = 4'd8,
		OPC_NONE   = 4'd15
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8,
		ALU_ULESS = 4'd9
	} alu_op_e;

	// raw opcode field in insn[6:0]
	localparam logic [6:0] RAW_LUI    = 7'b0110111;
	localparam logic [6:0] RAW_AUIPC  = 7'b0010111;
	localparam logic [6:0] RAW_JAL    = 7'b1101111;
	localparam logic [6:0] RAW_JALR   = 7'b1100111;
	localparam logic [6:0] RAW_BRANCH = 7'b1100011;
	localparam logic [6:0] RAW_STORE  = 7'b0100011;
	localparam logic [6:0] RAW_OP_IMM = 7'b0010011;
	localparam logic [6:0] RAW_OP     = 7'b0110011;
	localparam logic [6:0] RAW_SYSTEM = 7'b1110011;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// store widths
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// csr ops
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	// alu funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

endpackage

// ==== rv_exec_if.sv ====
`timescale 1ns/1ns

interface rv_exec_if import rv_pkg::*;;

	logic        valid;
	opcode_e     opc;
	alu_op_e     alu_op;
	logic [2:0]  funct3;
	logic [4:0]  rd;
	logic [31:0] lhs;     // alu operands
	logic [31:0] rhs;
	logic [31:0] src1;    // raw register values
	logic [31:0] src2;
	logic [31:0] imm;
	logic [31:0] pc;
	logic [31:0] csr_val;

	modport src (
		output valid, opc, alu_op, funct3, rd,
		output lhs, rhs,
		output src1, src2, imm, pc, csr_val
	);

	modport snk (
		input valid, opc, alu_op, funct3, rd,
		input lhs, rhs,
		input src1, src2, imm, pc, csr_val
	);

endinterface

// ==== rv_result_if.sv ====
`timescale 1ns/1ns

interface rv_result_if;

	logic        valid;
	logic [31:0] val;
	logic [31:0] jump;       // zero when not taken
	logic [3:0]  wmask;
	logic [31:0] csr_wdata;
	logic [4:0]  rd;

	modport src (
		output valid,
		output val, jump, wmask, csr_wdata, rd
	);

	modport snk (
		input valid,
		input val, jump, wmask, csr_wdata, rd
	);

endinterface

// ==== rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [31:0] in_insn,
	input  logic [31:0] in_pc,
	input  logic [31:0] in_src1,
	input  logic [31:0] in_src2,
	input  logic [31:0] in_csr_val,
	rv_exec_if.src      dec
);

	logic [6:0]  raw_opc;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	opcode_e     opc;
	alu_op_e     alu_op;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] imm;
	logic [31:0] lhs;
	logic [31:0] rhs;

	assign raw_opc = in_insn[6:0];
	assign funct3  = in_insn[14:12];
	assign funct7  = in_insn[31:25];

	assign imm_i = {{20{in_insn[31]}}, in_insn[31:20]};
	assign imm_s = {{20{in_insn[31]}}, in_insn[31:25], in_insn[11:7]};
	assign imm_b = {{19{in_insn[31]}}, in_insn[31], in_insn[7], in_insn[30:25], in_insn[11:8], 1'b0};
	assign imm_u = {in_insn[31:12], 12'b0};
	assign imm_j = {{11{in_insn[31]}}, in_insn[31], in_insn[19:12], in_insn[20], in_insn[30:21], 1'b0};

	always_comb begin
		case (raw_opc)
			RAW_LUI:    opc = OPC_LUI;
			RAW_AUIPC:  opc = OPC_AUIPC;
			RAW_JAL:    opc = OPC_JAL;
			RAW_JALR:   opc = OPC_JALR;
			RAW_BRANCH: opc = OPC_BRANCH;
			RAW_STORE:  opc = OPC_STORE;
			RAW_OP_IMM: opc = OPC_OP_IMM;
			RAW_OP:     opc = OPC_OP;
			RAW_SYSTEM: opc = OPC_SYSTEM;
			default:    opc = OPC_NONE;
		endcase
	end

	always_comb begin
		case (opc)
			OPC_LUI, OPC_AUIPC: imm = imm_u;
			OPC_JAL:            imm = imm_j;
			OPC_BRANCH:         imm = imm_b;
			OPC_STORE:          imm = imm_s;
			OPC_NONE:           imm = '0;
			default:            imm = imm_i;  // jalr, op_imm, system
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD;
		if (opc == OPC_OP || opc == OPC_OP_IMM) begin
			case (funct3)
				F3_ADD:  alu_op = (opc == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
				F3_SLL:  alu_op = ALU_SLL;
				F3_SLT:  alu_op = ALU_LESS;
				F3_SLTU: alu_op = ALU_ULESS;
				F3_XOR:  alu_op = ALU_XOR;
				F3_SR: begin
					if (funct7 == F7_ALT)
						alu_op = ALU_SRA;
					else if (funct7 == F7_BASE)
						alu_op = ALU_SRL;
					else
						alu_op = ALU_ADD;  // unknown funct7
				end
				F3_OR:   alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	// operand select per class
	always_comb begin
		case (opc)
			OPC_LUI:           begin lhs = imm;     rhs = '0;      end
			OPC_AUIPC:         begin lhs = in_pc;   rhs = imm;     end
			OPC_JAL, OPC_JALR: begin lhs = in_pc;   rhs = 32'd4;   end
			OPC_OP_IMM:        begin lhs = in_src1; rhs = imm;     end
			OPC_OP:            begin lhs = in_src1; rhs = in_src2; end
			default:           begin lhs = '0;      rhs = '0;      end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec.valid <= 1'b0;
		else
			dec.valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		dec.opc     <= opc;
		dec.alu_op  <= alu_op;
		dec.funct3  <= funct3;
		dec.rd      <= in_insn[11:7];
		dec.lhs     <= lhs;
		dec.rhs     <= rhs;
		dec.src1    <= in_src1;
		dec.src2    <= in_src2;
		dec.imm     <= imm;
		dec.pc      <= in_pc;
		dec.csr_val <= in_csr_val;
	end

endmodule

// ==== rv_exu.sv ====
`timescale 1ns/1ns

module rv_exu import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	rv_exec_if.snk   dec,
	rv_result_if.src res
);

	logic [32:0] alu_diff;
	logic        alu_less;
	logic        alu_uless;
	logic [4:0]  shamt;
	logic [31:0] val;

	logic [32:0] br_diff;
	logic        br_less;
	logic        br_uless;
	logic        br_ne;
	logic        br_cond;
	logic        jump_en;
	logic [31:0] jump_base;
	logic [31:0] jump;

	logic [3:0]  wmask;
	logic [31:0] csr_wdata;

	// one subtract feeds sub, slt and sltu
	assign alu_diff  = {1'b0, dec.lhs} - {1'b0, dec.rhs};
	assign alu_uless = alu_diff[32];
	assign alu_less  = (dec.lhs[31] & ~dec.rhs[31])
		| (~(dec.lhs[31] ^ dec.rhs[31]) & alu_diff[31]);
	assign shamt = dec.rhs[4:0];

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:   val = dec.lhs + dec.rhs;
			ALU_SUB:   val = alu_diff[31:0];
			ALU_AND:   val = dec.lhs & dec.rhs;
			ALU_XOR:   val = dec.lhs ^ dec.rhs;
			ALU_OR:    val = dec.lhs | dec.rhs;
			ALU_SRL:   val = dec.lhs >> shamt;
			ALU_SRA:   val = $signed(dec.lhs) >>> shamt;
			ALU_SLL:   val = dec.lhs << shamt;
			ALU_LESS:  val = {31'b0, alu_less};
			ALU_ULESS: val = {31'b0, alu_uless};
			default:   val = '0;
		endcase
	end

	// branch compare on raw registers
	assign br_diff  = {1'b0, dec.src1} - {1'b0, dec.src2};
	assign br_uless = br_diff[32];
	assign br_ne    = |br_diff[31:0];
	assign br_less  = (dec.src1[31] & ~dec.src2[31])
		| (~(dec.src1[31] ^ dec.src2[31]) & br_diff[31]);

	always_comb begin
		case (dec.funct3)
			F3_BEQ:  br_cond = ~br_ne;
			F3_BNE:  br_cond = br_ne;
			F3_BLT:  br_cond = br_less;
			F3_BGE:  br_cond = ~br_less;
			F3_BLTU: br_cond = br_uless;
			F3_BGEU: br_cond = ~br_uless;
			default: br_cond = 1'b0;
		endcase
	end

	assign jump_en = (dec.opc == OPC_JAL) || (dec.opc == OPC_JALR)
		|| (dec.opc == OPC_BRANCH && br_cond);
	assign jump_base = (dec.opc == OPC_JALR) ? dec.src1 : dec.pc;
	assign jump      = jump_en ? jump_base + dec.imm : '0;

	always_comb begin
		wmask = 4'h0;
		if (dec.opc == OPC_STORE) begin
			case (dec.funct3)
				F3_SB:   wmask = 4'h1;
				F3_SH:   wmask = 4'h3;
				F3_SW:   wmask = 4'hf;
				default: wmask = 4'h0;
			endcase
		end
	end

	always_comb begin
		csr_wdata = '0;
		if (dec.opc == OPC_SYSTEM) begin
			case (dec.funct3)
				F3_CSRRW: csr_wdata = dec.src1;
				F3_CSRRS: csr_wdata = dec.src1 | dec.csr_val;
				default:  csr_wdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			res.valid <= 1'b0;
		else
			res.valid <= dec.valid;
	end

	always_ff @(posedge clk) begin
		res.val       <= val;
		res.jump      <= jump;
		res.wmask     <= wmask;
		res.csr_wdata <= csr_wdata;
		res.rd        <= dec.rd;
	end

endmodule

// ==== rv_result_buf.sv ====
`timescale 1ns/1ns

module rv_result_buf #(
	parameter int DEPTH       = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst,
	rv_result_if.snk    res,
	input  logic        out_credit,
	output logic        in_credit,
	output logic        out_valid,
	output logic [31:0] out_val,
	output logic [31:0] out_jump,
	output logic [3:0]  out_wmask,
	output logic [31:0] out_csr_wdata,
	output logic [4:0]  out_rd
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam int KW = $clog2(OUT_CREDITS + 1) + 1;  // headroom on returns

	logic [31:0] val_mem  [DEPTH];
	logic [31:0] jump_mem [DEPTH];
	logic [3:0]  mask_mem [DEPTH];
	logic [31:0] csr_mem  [DEPTH];
	logic [4:0]  rd_mem   [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [KW-1:0] credits;
	logic          push;
	logic          pop;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push = res.valid;  // upstream credits keep it from overflowing
	assign pop  = (count != '0) && (credits != '0);

	assign out_valid     = pop;
	assign in_credit     = pop;  // slot freed
	assign out_val       = val_mem[rd_ptr];
	assign out_jump      = jump_mem[rd_ptr];
	assign out_wmask     = mask_mem[rd_ptr];
	assign out_csr_wdata = csr_mem[rd_ptr];
	assign out_rd        = rd_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			val_mem[wr_ptr]  <= res.val;
			jump_mem[wr_ptr] <= res.jump;
			mask_mem[wr_ptr] <= res.wmask;
			csr_mem[wr_ptr]  <= res.csr_wdata;
			rd_mem[wr_ptr]   <= res.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= KW'(OUT_CREDITS);
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			credits <= credits + KW'(out_credit) - KW'(pop);
		end
	end

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ns

module rv_exec_top #(
	parameter int DEPTH       = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [31:0] in_insn,
	input  logic [31:0] in_pc,
	input  logic [31:0] in_src1,
	input  logic [31:0] in_src2,
	input  logic [31:0] in_csr_val,
	output logic        in_credit,
	output logic        out_valid,
	output logic [31:0] out_val,
	output logic [31:0] out_jump,
	output logic [3:0]  out_wmask,
	output logic [31:0] out_csr_wdata,
	output logic [4:0]  out_rd,
	input  logic        out_credit
);

	rv_exec_if   dec_if ();
	rv_result_if res_if ();

	rv_decoder decoder_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_insn    (in_insn),
		.in_pc      (in_pc),
		.in_src1    (in_src1),
		.in_src2    (in_src2),
		.in_csr_val (in_csr_val),
		.dec        (dec_if.src)
	);

	rv_exu exu_i (
		.clk (clk),
		.rst (rst),
		.dec (dec_if.snk),
		.res (res_if.src)
	);

	rv_result_buf #(
		.DEPTH       (DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) buf_i (
		.clk           (clk),
		.rst           (rst),
		.res           (res_if.snk),
		.out_credit    (out_credit),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_val       (out_val),
		.out_jump      (out_jump),
		.out_wmask     (out_wmask),
		.out_csr_wdata (out_csr_wdata),
		.out_rd        (out_rd)
	);

endmodule

// ==== tb_rv_exec.sv ====
`timescale 1ns/1ns

module tb_rv_exec import rv_pkg::*; ();

	localparam int DEPTH       = 4;
	localparam int OUT_CREDITS = 2;
	localparam int PERIOD      = 40;
	localparam int N_ITEMS     = 40;  // per test
	localparam int N_TOTAL     = 5 * N_ITEMS;
	localparam int WATCHDOG_NS = (N_TOTAL * 40 + 50) * PERIOD;

	typedef struct packed {
		logic [31:0] val;
		logic [31:0] jump;
		logic [3:0]  wmask;
		logic [31:0] csr;
		logic [4:0]  rd;
	} result_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [31:0] in_insn;
	logic [31:0] in_pc;
	logic [31:0] in_src1;
	logic [31:0] in_src2;
	logic [31:0] in_csr_val;
	logic        in_credit;
	logic        out_valid;
	logic [31:0] out_val;
	logic [31:0] out_jump;
	logic [3:0]  out_wmask;
	logic [31:0] out_csr_wdata;
	logic [4:0]  out_rd;
	logic        out_credit;

	logic [31:0] seed = 32'h09f2_919b;
	result_t     exp_q[$];
	int          errors     = 0;
	int          up_credits = DEPTH;
	int          owed       = 0;  // results taken with no credit returned yet
	int          delivered  = 0;
	int          returned   = 0;
	int          total_sent = 0;
	bit          throttle   = 1'b0;

	rv_exec_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] rnd();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// kind 0 alu, 1 upper/jump, 2 branch, 3 store/csr, 4 mixed
	function automatic logic [31:0] gen_insn(input int kind);
		logic [31:0] w;
		logic [31:0] sel;
		logic [2:0]  f3;
		int          k;
		w   = rnd();
		sel = rnd();
		k   = (kind == 4) ? int'(sel[1:0]) : kind;
		f3  = w[14:12];
		case (k)
			0: begin
				if (sel[8]) begin
					w[6:0]   = RAW_OP;
					w[31:25] = ((f3 == F3_ADD || f3 == F3_SR) && sel[9]) ? F7_ALT : F7_BASE;
				end else begin
					w[6:0] = RAW_OP_IMM;
					if (f3 == F3_SR)
						w[31:25] = sel[9] ? F7_ALT : F7_BASE;
				end
			end
			1: begin
				case (sel[9:8])
					2'd0: w[6:0] = RAW_LUI;
					2'd1: w[6:0] = RAW_AUIPC;
					2'd2: w[6:0] = RAW_JAL;
					default: begin
						w[6:0]   = RAW_JALR;
						w[14:12] = 3'b000;
					end
				endcase
			end
			2: begin
				w[6:0] = RAW_BRANCH;
				if (f3[2:1] == 2'b01)
					f3 = {2'b10, f3[0]};  // 010/011 are no branch
				w[14:12] = f3;
			end
			default: begin
				if (sel[8]) begin
					w[6:0]   = RAW_STORE;
					w[14:12] = (f3[1:0] == 2'b11) ? F3_SW : {1'b0, f3[1:0]};
				end else begin
					w[6:0]   = RAW_SYSTEM;
					w[14:12] = f3[0] ? F3_CSRRS : F3_CSRRW;
				end
			end
		endcase
		if (kind == 4 && sel[4:2] == 3'd0)
			w[6:0] = 7'b0000011;  // load decodes to none
		return w;
	endfunction

	// expected result straight from the RV32I encoding
	function automatic result_t model(input logic [31:0] insn, input logic [31:0] pc,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] csr);
		result_t     r;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] opb;
		logic [2:0]  f3;
		logic        taken;
		f3    = insn[14:12];
		imm_i = {{20{insn[31]}}, insn[31:20]};
		imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
		imm_u = {insn[31:12], 12'h000};
		imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
		r     = '0;
		r.rd  = insn[11:7];
		taken = 1'b0;
		case (insn[6:0])
			RAW_LUI:   r.val = imm_u;
			RAW_AUIPC: r.val = pc + imm_u;
			RAW_JAL: begin
				r.val  = pc + 32'd4;
				r.jump = pc + imm_j;
			end
			RAW_JALR: begin
				r.val  = pc + 32'd4;
				r.jump = a + imm_i;
			end
			RAW_BRANCH: begin
				case (f3)
					F3_BEQ:  taken = (a == b);
					F3_BNE:  taken = (a != b);
					F3_BLT:  taken = ($signed(a) < $signed(b));
					F3_BGE:  taken = ($signed(a) >= $signed(b));
					F3_BLTU: taken = (a < b);
					F3_BGEU: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken)
					r.jump = pc + imm_b;
			end
			RAW_STORE: r.wmask = (f3 == F3_SB) ? 4'h1 : (f3 == F3_SH) ? 4'h3 : 4'hf;
			RAW_SYSTEM: r.csr = (f3 == F3_CSRRW) ? a : (a | csr);
			RAW_OP, RAW_OP_IMM: begin
				opb = (insn[6:0] == RAW_OP) ? b : imm_i;
				case (f3)
					F3_ADD:  r.val = (insn[6:0] == RAW_OP && insn[30]) ? a - opb : a + opb;
					F3_SLL:  r.val = a << opb[4:0];
					F3_SLT:  r.val = {31'b0, $signed(a) < $signed(opb)};
					F3_SLTU: r.val = {31'b0, a < opb};
					F3_XOR:  r.val = a ^ opb;
					F3_SR: begin
						if (insn[30])
							r.val = $signed(a) >>> opb[4:0];
						else
							r.val = a >> opb[4:0];
					end
					F3_OR:   r.val = a | opb;
					default: r.val = a & opb;
				endcase
			end
			default: r.val = '0;  // rd still passes through
		endcase
		return r;
	endfunction

	// one clock with upstream and downstream credit bookkeeping
	task automatic tick();
		@(posedge clk);
		if (in_credit)
			up_credits++;
		if (up_credits > DEPTH) begin
			$display("upstream got back more credits than items were issued");
			errors++;
		end
		if (out_valid)
			owed++;
		if (out_credit)
			owed--;
		in_valid   <= 1'b0;
		out_credit <= (owed > 0) && ((rnd() % 4) < (throttle ? 1 : 3));
	endtask

	task automatic run_test(input string name, input int kind, input bit slow);
		int          sent;
		int          err0;
		logic [31:0] insn;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] csr;
		sent     = 0;
		err0     = errors;
		throttle = slow;
		while (sent < N_ITEMS) begin
			tick();
			if (up_credits > 0 && (rnd() % 4) != 0) begin
				insn = gen_insn(kind);
				pc   = rnd() & ~32'h3;
				a    = rnd();
				b    = rnd();
				csr  = rnd();
				if (b[3:0] == 4'h0)
					b = a;  // equal operands for beq/bge
				in_valid   <= 1'b1;
				in_insn    <= insn;
				in_pc      <= pc;
				in_src1    <= a;
				in_src2    <= b;
				in_csr_val <= csr;
				exp_q.push_back(model(insn, pc, a, b, csr));
				up_credits--;
				sent++;
			end
		end
		while (exp_q.size() != 0)
			tick();
		total_sent += sent;
		$display("test %-12s %0d items, %0d errors", name, sent, errors - err0);
	endtask

	// every result on the output is checked against the queue head
	always @(posedge clk) begin
		result_t e;
		if (!rst) begin
			if (in_credit !== out_valid) begin
				$display("ERR in_credit got %h exp %h", in_credit, out_valid);
				errors++;
			end
			if (out_valid === 1'b1) begin
				delivered++;
				if (delivered > returned + OUT_CREDITS) begin
					$display("result sent without a downstream credit");
					errors++;
				end
				if (exp_q.size() == 0) begin
					$display("result came out with no instruction outstanding");
					errors++;
				end else begin
					e = exp_q.pop_front();
					if (out_val !== e.val) begin
						$display("ERR out_val got %h exp %h", out_val, e.val);
						errors++;
					end
					if (out_jump !== e.jump) begin
						$display("ERR out_jump got %h exp %h", out_jump, e.jump);
						errors++;
					end
					if (out_wmask !== e.wmask) begin
						$display("ERR out_wmask got %h exp %h", out_wmask, e.wmask);
						errors++;
					end
					if (out_csr_wdata !== e.csr) begin
						$display("ERR out_csr_wdata got %h exp %h", out_csr_wdata, e.csr);
						errors++;
					end
					if (out_rd !== e.rd) begin
						$display("ERR out_rd got %h exp %h", out_rd, e.rd);
						errors++;
					end
				end
			end
			if (out_credit)
				returned++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, results still outstanding", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int err0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_insn    = '0;
		in_pc      = '0;
		in_src1    = '0;
		in_src2    = '0;
		in_csr_val = '0;
		out_credit = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		err0 = errors;
		repeat (10) tick();  // idle so nothing may come out
		$display("test %-12s %0d items, %0d errors", "reset_idle", 0, errors - err0);
		run_test("alu", 0, 1'b0);
		run_test("upper_jump", 1, 1'b0);
		run_test("branch", 2, 1'b0);
		run_test("store_csr", 3, 1'b0);
		run_test("mixed_slow", 4, 1'b1);
		$display("tests 6, items %0d, results %0d, errors %0d", total_sent, delivered, errors);
		if (errors == 0 && delivered == total_sent)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim.f ====
rv_pkg.sv
rv_exec_if.sv
rv_result_if.sv
rv_decoder.sv
rv_exu.sv
rv_result_buf.sv
rv_exec_top.sv
tb_rv_exec.sv

// ==== Makefile ====
TOP := tb_rv_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation passed'

clean:
	rm -rf obj_dir
